/* src.f */
verilog/lock_pkg.sv
verilog/key_event_if.sv
verilog/key_decoder.sv
verilog/code_entry.sv
verilog/lockout_timer.sv
verilog/buzzer_pattern.sv
verilog/keypad_lock_top.sv
test/keypad_lock_props.sv
test/tb_keypad_lock.sv

/* test/keypad_lock_props.sv */
module keypad_lock_props #(
    parameter lock_pkg::display_t PASSCODE      = 12'h246,
    parameter int                 MAX_TRIES     = 4,
    parameter int                 TICKS_PER_SEC = 50
) (
    input logic                   clk,
    input logic                   rst,
    input lock_pkg::keys_t        keys,
    input lock_pkg::display_t     display,
    input lock_pkg::digit_count_t digit_count,
    input lock_pkg::fail_count_t  fail_count,
    input logic                   locked,
    input logic                   buzzer
);

    localparam int LOCK_MAX = TICKS_PER_SEC * 60 + 4;

    logic                   failed = 1'b0;   // watched by the testbench
    lock_pkg::keys_t        k1, k2, k3;      // keypad history
    lock_pkg::display_t     disp1;
    lock_pkg::digit_count_t cnt1;
    lock_pkg::fail_count_t  fail1;
    logic                   lock1;
    logic [4:0]             dig;             // {is digit, value}
    logic                   new_key;
    logic                   ev_digit, ev_enter, ev_clear, ev_master;
    lock_pkg::display_t     exp_shift;
    lock_pkg::display_t     exp_fail_disp;
    logic                   exp_lock;

    // keypad wiring of the digit keys
    function automatic logic [4:0] key_digit(input lock_pkg::keys_t k);
        case (k)
            16'h0008: return 5'h10;
            16'h0080: return 5'h11;
            16'h0040: return 5'h12;
            16'h0020: return 5'h13;
            16'h0800: return 5'h14;
            16'h0400: return 5'h15;
            16'h0200: return 5'h16;
            16'h8000: return 5'h17;
            16'h4000: return 5'h18;
            16'h2000: return 5'h19;
            default:  return 5'h00;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        k1    <= keys;
        k2    <= k1;
        k3    <= k2;
        disp1 <= display;
        cnt1  <= digit_count;
        fail1 <= fail_count;
        lock1 <= locked;
    end

    // key acted on by the lock one edge ago
    assign dig           = key_digit(k2);
    assign new_key       = (k2 != k3);
    assign ev_digit      = new_key && dig[4];
    assign ev_enter      = new_key && (k2 == 16'h0001);
    assign ev_master     = new_key && (k2 == 16'h0100);
    assign ev_clear      = new_key && (k2 == 16'h1000);
    assign exp_shift     = {disp1[7:0], dig[3:0]};
    assign exp_lock      = ((fail1 + 4'd1) == MAX_TRIES);
    assign exp_fail_disp = exp_lock ? 12'h000 : 12'hFFF;

    a_reset: assert property (@(posedge clk) $fell(rst) |->
        display == 12'hFFF && digit_count == 0 && fail_count == 0 && !locked && !buzzer)
    else begin
        failed = 1'b1;
        $error("MISMATCH reset_values expected fff/0/0/0/0 actual %h/%0d/%0d/%b/%b",
            $sampled(display), $sampled(digit_count), $sampled(fail_count),
            $sampled(locked), $sampled(buzzer));
    end

    a_digit: assert property (@(posedge clk) disable iff (rst)
        ev_digit && !lock1 && cnt1 != 2'd3 |->
        display == exp_shift && digit_count == cnt1 + 2'd1)
    else begin
        failed = 1'b1;
        $error("MISMATCH digit_entry expected %h/%0d actual %h/%0d", $sampled(exp_shift),
            $sampled(cnt1) + 1, $sampled(display), $sampled(digit_count));
    end

    a_click: assert property (@(posedge clk) disable iff (rst)
        ev_digit && !lock1 && cnt1 != 2'd3 |=> buzzer)
    else begin
        failed = 1'b1;
        $error("MISMATCH key_click expected buzzer 1 actual %b", $sampled(buzzer));
    end

    a_full: assert property (@(posedge clk) disable iff (rst)
        ev_digit && cnt1 == 2'd3 |-> display == disp1)
    else begin
        failed = 1'b1;
        $error("MISMATCH fourth_digit expected %h actual %h", $sampled(disp1),
            $sampled(display));
    end

    a_pass: assert property (@(posedge clk) disable iff (rst)
        ev_enter && !lock1 && cnt1 == 2'd3 && disp1 == PASSCODE |->
        display == 12'hBCC && fail_count == fail1)
    else begin
        failed = 1'b1;
        $error("MISMATCH correct_code expected bcc/%0d actual %h/%0d", $sampled(fail1),
            $sampled(display), $sampled(fail_count));
    end

    a_held: assert property (@(posedge clk) disable iff (rst)
        disp1 == 12'hBCC && !lock1 && (ev_digit || ev_enter) |-> display == 12'hBCC)
    else begin
        failed = 1'b1;
        $error("MISMATCH pass_hold expected bcc actual %h", $sampled(display));
    end

    a_fail: assert property (@(posedge clk) disable iff (rst)
        ev_enter && !lock1 && cnt1 == 2'd3 && disp1 != PASSCODE && disp1 != 12'hBCC |->
        display == exp_fail_disp && digit_count == 0 &&
        fail_count == fail1 + 4'd1 && locked == exp_lock)
    else begin
        failed = 1'b1;
        $error("MISMATCH wrong_code expected %h/0/%0d/%b actual %h/%0d/%0d/%b",
            $sampled(exp_fail_disp), $sampled(fail1) + 1, $sampled(exp_lock),
            $sampled(display), $sampled(digit_count), $sampled(fail_count),
            $sampled(locked));
    end

    a_short: assert property (@(posedge clk) disable iff (rst)
        ev_enter && !lock1 && cnt1 != 2'd3 |->
        display == disp1 && digit_count == cnt1 && fail_count == fail1)
    else begin
        failed = 1'b1;
        $error("MISMATCH short_enter expected %h/%0d/%0d actual %h/%0d/%0d",
            $sampled(disp1), $sampled(cnt1), $sampled(fail1),
            $sampled(display), $sampled(digit_count), $sampled(fail_count));
    end

    a_lock_show: assert property (@(posedge clk) disable iff (rst)
        locked && lock1 |-> display[11:8] == 0 && display[7:4] <= 5 &&
        display[3:0] <= 9 && display[7:0] >= disp1[7:0] &&
        digit_count == cnt1 && fail_count == fail1)
    else begin
        failed = 1'b1;
        $error("MISMATCH lockout_seconds expected 0%h or above/%0d/%0d actual %h/%0d/%0d",
            $sampled(disp1[7:0]), $sampled(cnt1), $sampled(fail1),
            $sampled(display), $sampled(digit_count), $sampled(fail_count));
    end

    a_lock_len: assert property (@(posedge clk) disable iff (rst)
        $rose(locked) |-> ##[1:LOCK_MAX] !locked)
    else begin
        failed = 1'b1;
        $error("lockout lasted longer than %0d cycles", LOCK_MAX);
    end

    a_release: assert property (@(posedge clk) disable iff (rst)
        $fell(locked) |-> display == 12'hFFF && fail_count == 0 && digit_count == 0)
    else begin
        failed = 1'b1;
        $error("MISMATCH lockout_end expected fff/0/0 actual %h/%0d/%0d",
            $sampled(display), $sampled(fail_count), $sampled(digit_count));
    end

    a_clear: assert property (@(posedge clk) disable iff (rst)
        ev_clear && !lock1 |->
        display == 12'hFFF && digit_count == 0 && fail_count == fail1)
    else begin
        failed = 1'b1;
        $error("MISMATCH clear expected fff/0/%0d actual %h/%0d/%0d", $sampled(fail1),
            $sampled(display), $sampled(digit_count), $sampled(fail_count));
    end

    a_master: assert property (@(posedge clk) disable iff (rst)
        ev_master |->
        display == 12'hFFF && digit_count == 0 && fail_count == 0 && !locked)
    else begin
        failed = 1'b1;
        $error("MISMATCH master_clear expected fff/0/0/0 actual %h/%0d/%0d/%b",
            $sampled(display), $sampled(digit_count), $sampled(fail_count),
            $sampled(locked));
    end

endmodule

/* test/tb_keypad_lock.sv */
module tb_keypad_lock;

    localparam int CYCLE_LIMIT = 3000;   // two full lockouts plus key sequences

    logic                   clk;
    logic                   rst;
    lock_pkg::keys_t        keys;
    lock_pkg::display_t     display;
    lock_pkg::digit_count_t digit_count;
    lock_pkg::fail_count_t  fail_count;
    logic                   locked;
    logic                   buzzer;
    logic [31:0]            rng;
    int                     cycles;

    keypad_lock_top #(
        .PASSCODE      (12'h246),
        .MAX_TRIES     (4),
        .TICKS_PER_SEC (4),
        .CLICK_LEN     (12),
        .PASS_LEN      (30),
        .FAIL_LEN      (24),
        .CLICK_HALF    (2),
        .PASS_HALF     (3),
        .FAIL_HALF     (4)
    ) keypad_lock_top_i (
        .clk         (clk),
        .rst         (rst),
        .keys        (keys),
        .display     (display),
        .digit_count (digit_count),
        .fail_count  (fail_count),
        .locked      (locked),
        .buzzer      (buzzer)
    );

    bind keypad_lock_top keypad_lock_props #(
        .PASSCODE      (PASSCODE),
        .MAX_TRIES     (MAX_TRIES),
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) props_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic lock_pkg::keys_t digit_key(input int d);
        case (d)
            0:       return 16'h0008;
            1:       return 16'h0080;
            2:       return 16'h0040;
            3:       return 16'h0020;
            4:       return 16'h0800;
            5:       return 16'h0400;
            6:       return 16'h0200;
            7:       return 16'h8000;
            8:       return 16'h4000;
            default: return 16'h2000;
        endcase
    endfunction

    // hold 3 cycles, release 3 cycles, stays 1 unit after an edge
    task automatic press_key(input lock_pkg::keys_t k);
        keys = k;
        repeat (3) @(posedge clk);
        #1;
        keys = '0;
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic enter_code(input int d2, input int d1, input int d0);
        press_key(digit_key(d2));
        press_key(digit_key(d1));
        press_key(digit_key(d0));
        press_key(16'h0001);
    endtask

    task automatic enter_wrong_code();
        int d[3];
        for (int i = 0; i < 3; i++) begin
            rng  = xorshift(rng);
            d[i] = rng % 10;
        end
        if (d[0] == 2 && d[1] == 4 && d[2] == 6) begin
            d[2] = 7;   // never the real code
        end
        enter_code(d[0], d[1], d[2]);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    always @(negedge clk) begin
        if (keypad_lock_top_i.props_i.failed) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "an assertion on the lock outputs failed");
        end
    end

    initial begin
        rst    = 1'b1;
        keys   = '0;
        rng    = 32'd35218;
        cycles = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;

        press_key(digit_key(3));    // short enter does nothing
        press_key(digit_key(9));
        press_key(16'h0001);
        press_key(digit_key(1));
        press_key(digit_key(5));    // fourth digit ignored
        press_key(16'h1000);

        enter_code(2, 4, 6);
        press_key(digit_key(8));    // ignored after pass
        press_key(16'h0001);
        press_key(16'h1000);

        for (int i = 0; i < 3; i++) enter_wrong_code();
        press_key(16'h1000);        // clear keeps fail count
        enter_wrong_code();         // fourth fail locks
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            press_key(digit_key(rng % 10));
        end
        while (locked) begin
            @(posedge clk);
            #1;
        end

        for (int i = 0; i < 2; i++) enter_wrong_code();
        press_key(16'h0100);        // master clears fails
        for (int i = 0; i < 4; i++) enter_wrong_code();
        while (locked) begin
            @(posedge clk);
            #1;
        end

        for (int i = 0; i < 4; i++) enter_wrong_code();
        repeat (40) @(posedge clk);
        #1;
        press_key(16'h0100);        // master during lockout
        enter_code(2, 4, 6);
        repeat (4) @(posedge clk);
        #1;

        if (keypad_lock_top_i.props_i.failed) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "an assertion on the lock outputs failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* verilog/buzzer_pattern.sv */
module buzzer_pattern #(
    parameter int CLICK_LEN  = 5,
    parameter int PASS_LEN   = 50,
    parameter int FAIL_LEN   = 45,
    parameter int CLICK_HALF = 1,
    parameter int PASS_HALF  = 1,
    parameter int FAIL_HALF  = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  lock_pkg::buzz_kind_t kind,
    output logic                 buzzer
);

    localparam int LEN_MAX  = (CLICK_LEN > PASS_LEN) ?
                              ((CLICK_LEN > FAIL_LEN) ? CLICK_LEN : FAIL_LEN) :
                              ((PASS_LEN > FAIL_LEN) ? PASS_LEN : FAIL_LEN);
    localparam int HALF_MAX = (CLICK_HALF > PASS_HALF) ?
                              ((CLICK_HALF > FAIL_HALF) ? CLICK_HALF : FAIL_HALF) :
                              ((PASS_HALF > FAIL_HALF) ? PASS_HALF : FAIL_HALF);
    localparam int DW = $clog2(LEN_MAX + 1);
    localparam int HW = $clog2(HALF_MAX + 1);

    // silent middle third of the fail tone
    localparam logic [DW-1:0] MUTE_LO = DW'(FAIL_LEN / 3);
    localparam logic [DW-1:0] MUTE_HI = DW'((2 * FAIL_LEN) / 3);

    lock_pkg::buzz_kind_t kind_q;
    logic                 active;
    logic                 tone;
    logic                 mute;
    logic [DW-1:0]        dur;        // cycles into the pattern
    logic [DW-1:0]        len_last;
    logic [HW-1:0]        half;       // cycles into the half-period
    logic [HW-1:0]        half_last;

    always_comb begin
        case (kind_q)
            lock_pkg::BUZZ_PASS: begin
                len_last  = DW'(PASS_LEN - 1);
                half_last = HW'(PASS_HALF - 1);
            end
            lock_pkg::BUZZ_FAIL: begin
                len_last  = DW'(FAIL_LEN - 1);
                half_last = HW'(FAIL_HALF - 1);
            end
            default: begin
                len_last  = DW'(CLICK_LEN - 1);
                half_last = HW'(CLICK_HALF - 1);
            end
        endcase
    end

    assign mute   = (kind_q == lock_pkg::BUZZ_FAIL) && (dur >= MUTE_LO) && (dur < MUTE_HI);
    assign buzzer = active && tone && !mute;

    always_ff @(posedge clk) begin
        if (rst) begin
            kind_q <= lock_pkg::BUZZ_CLICK;
            active <= 1'b0;
            tone   <= 1'b0;
            dur    <= '0;
            half   <= '0;
        end else if (req) begin
            kind_q <= kind;      // a new request always wins
            active <= 1'b1;
            tone   <= 1'b1;
            dur    <= '0;
            half   <= '0;
        end else if (active) begin
            dur <= dur + 1'b1;
            if (dur == len_last) begin
                active <= 1'b0;  // pattern over, rest low
                tone   <= 1'b0;
            end else if (half == half_last) begin
                half <= '0;
                tone <= ~tone;
            end else begin
                half <= half + 1'b1;
            end
        end
    end

endmodule

/* verilog/code_entry.sv */
module code_entry #(
    parameter lock_pkg::display_t PASSCODE  = 12'h246,
    parameter int                 MAX_TRIES = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    key_event_if.sink              ev,
    input  lock_pkg::bcd_t         sec_tens,
    input  lock_pkg::bcd_t         sec_units,
    input  logic                   lock_done,
    output logic                   lock_run,
    output lock_pkg::display_t     display,
    output lock_pkg::digit_count_t digit_count,
    output lock_pkg::fail_count_t  fail_count,
    output logic                   buzz_req,
    output lock_pkg::buzz_kind_t   buzz_kind
);

    typedef enum logic [1:0] {
        ENTRY,
        PASSED,
        LOCKED
    } state_t;

    localparam lock_pkg::fail_count_t TRIP = lock_pkg::fail_count_t'(MAX_TRIES);

    state_t                state;
    lock_pkg::display_t    digits;     // entered digits, shifted left
    lock_pkg::fail_count_t fail_next;

    assign fail_next = fail_count + 4'd1;
    assign lock_run  = (state == LOCKED);

    always_comb begin
        case (state)
            PASSED:  display = lock_pkg::DISP_PASS;
            LOCKED:  display = {lock_pkg::DISP_LOCK[11:8], sec_tens, sec_units};
            default: display = digits;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ENTRY;
            digits      <= lock_pkg::DISP_BLANK;
            digit_count <= '0;
            fail_count  <= '0;
            buzz_req    <= 1'b0;
            buzz_kind   <= lock_pkg::BUZZ_CLICK;
        end else begin
            buzz_req <= 1'b0;
            if (ev.press && ev.is_master) begin
                state       <= ENTRY;
                digits      <= lock_pkg::DISP_BLANK;
                digit_count <= '0;
                fail_count  <= '0;
                buzz_req    <= 1'b1;
                buzz_kind   <= lock_pkg::BUZZ_CLICK;
            end else if (state == LOCKED) begin
                // only the timer can release us here
                if (lock_done) begin
                    state       <= ENTRY;
                    digits      <= lock_pkg::DISP_BLANK;
                    digit_count <= '0;
                    fail_count  <= '0;
                end
            end else if (ev.press && ev.is_clear) begin
                state       <= ENTRY;
                digits      <= lock_pkg::DISP_BLANK;
                digit_count <= '0;
                buzz_req    <= 1'b1;
                buzz_kind   <= lock_pkg::BUZZ_CLICK;
            end else if (state == ENTRY && ev.press) begin
                if (ev.is_digit && digit_count != 2'd3) begin
                    digits      <= {digits[7:0], ev.digit};  // newest in low nibble
                    digit_count <= digit_count + 2'd1;
                    buzz_req    <= 1'b1;
                    buzz_kind   <= lock_pkg::BUZZ_CLICK;
                end else if (ev.is_enter && digit_count == 2'd3) begin
                    buzz_req <= 1'b1;
                    if (digits == PASSCODE) begin
                        state     <= PASSED;
                        buzz_kind <= lock_pkg::BUZZ_PASS;
                    end else begin
                        digits      <= lock_pkg::DISP_BLANK;
                        digit_count <= '0;
                        fail_count  <= fail_next;
                        buzz_kind   <= lock_pkg::BUZZ_FAIL;
                        if (fail_next == TRIP) begin
                            state <= LOCKED;  // trip limit reached
                        end
                    end
                end
            end
        end
    end

endmodule

/* verilog/key_decoder.sv */
module key_decoder (
    input  logic            clk,
    input  logic            rst,
    input  lock_pkg::keys_t keys,
    key_event_if.source     ev
);

    lock_pkg::keys_t keys_q;    // sampled keypad
    lock_pkg::keys_t prev_q;    // code seen one cycle earlier
    lock_pkg::bcd_t  digit;
    logic            is_digit;
    logic            is_enter;
    logic            is_clear;
    logic            is_master;
    logic            valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            keys_q <= '0;
            prev_q <= '0;
        end else begin
            keys_q <= keys;
            prev_q <= keys_q;
        end
    end

    // map the one-hot code to an event, anything else decodes to nothing
    always_comb begin
        digit     = 4'h0;
        is_digit  = 1'b1;
        is_enter  = 1'b0;
        is_clear  = 1'b0;
        is_master = 1'b0;
        case (keys_q)
            lock_pkg::KEY_D0:     digit = 4'd0;
            lock_pkg::KEY_D1:     digit = 4'd1;
            lock_pkg::KEY_D2:     digit = 4'd2;
            lock_pkg::KEY_D3:     digit = 4'd3;
            lock_pkg::KEY_D4:     digit = 4'd4;
            lock_pkg::KEY_D5:     digit = 4'd5;
            lock_pkg::KEY_D6:     digit = 4'd6;
            lock_pkg::KEY_D7:     digit = 4'd7;
            lock_pkg::KEY_D8:     digit = 4'd8;
            lock_pkg::KEY_D9:     digit = 4'd9;
            lock_pkg::KEY_ENTER:  {is_digit, is_enter}  = 2'b01;
            lock_pkg::KEY_CLEAR:  {is_digit, is_clear}  = 2'b01;
            lock_pkg::KEY_MASTER: {is_digit, is_master} = 2'b01;
            default:              is_digit = 1'b0;   // idle or several keys
        endcase
    end

    assign valid = is_digit | is_enter | is_clear | is_master;

    assign ev.press     = valid && (keys_q != prev_q);  // once per new code
    assign ev.digit     = digit;
    assign ev.is_digit  = is_digit;
    assign ev.is_enter  = is_enter;
    assign ev.is_clear  = is_clear;
    assign ev.is_master = is_master;

endmodule

/* verilog/key_event_if.sv */
interface key_event_if;

    logic           press;      // strobe, new valid key code
    lock_pkg::bcd_t digit;      // digit value, valid with is_digit
    logic           is_digit;
    logic           is_enter;
    logic           is_clear;
    logic           is_master;  // clears everything, even lockout

    modport source (
        output press, digit, is_digit, is_enter, is_clear, is_master
    );

    modport sink (
        input press, digit, is_digit, is_enter, is_clear, is_master
    );

endinterface

/* verilog/keypad_lock_top.sv */
module keypad_lock_top #(
    parameter lock_pkg::display_t PASSCODE      = 12'h246,
    parameter int                 MAX_TRIES     = 4,
    parameter int                 TICKS_PER_SEC = 50,
    parameter int                 CLICK_LEN     = 5,
    parameter int                 PASS_LEN      = 50,
    parameter int                 FAIL_LEN      = 45,
    parameter int                 CLICK_HALF    = 1,
    parameter int                 PASS_HALF     = 1,
    parameter int                 FAIL_HALF     = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  lock_pkg::keys_t        keys,
    output lock_pkg::display_t     display,
    output lock_pkg::digit_count_t digit_count,
    output lock_pkg::fail_count_t  fail_count,
    output logic                   locked,
    output logic                   buzzer
);

    lock_pkg::bcd_t       sec_tens;
    lock_pkg::bcd_t       sec_units;
    logic                 lock_run;
    logic                 lock_done;
    logic                 buzz_req;
    lock_pkg::buzz_kind_t buzz_kind;

    key_event_if key_ev ();   // decoded key events

    key_decoder key_decoder_i (
        .clk  (clk),
        .rst  (rst),
        .keys (keys),
        .ev   (key_ev)
    );

    code_entry #(
        .PASSCODE  (PASSCODE),
        .MAX_TRIES (MAX_TRIES)
    ) code_entry_i (
        .clk         (clk),
        .rst         (rst),
        .ev          (key_ev),
        .sec_tens    (sec_tens),
        .sec_units   (sec_units),
        .lock_done   (lock_done),
        .lock_run    (lock_run),
        .display     (display),
        .digit_count (digit_count),
        .fail_count  (fail_count),
        .buzz_req    (buzz_req),
        .buzz_kind   (buzz_kind)
    );

    lockout_timer #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) lockout_timer_i (
        .clk       (clk),
        .rst       (rst),
        .run       (lock_run),
        .sec_tens  (sec_tens),
        .sec_units (sec_units),
        .done      (lock_done)
    );

    buzzer_pattern #(
        .CLICK_LEN  (CLICK_LEN),
        .PASS_LEN   (PASS_LEN),
        .FAIL_LEN   (FAIL_LEN),
        .CLICK_HALF (CLICK_HALF),
        .PASS_HALF  (PASS_HALF),
        .FAIL_HALF  (FAIL_HALF)
    ) buzzer_pattern_i (
        .clk    (clk),
        .rst    (rst),
        .req    (buzz_req),
        .kind   (buzz_kind),
        .buzzer (buzzer)
    );

    assign locked = lock_run;  // lockout runs exactly while locked

endmodule

/* verilog/lock_pkg.sv */
package lock_pkg;

    typedef logic [3:0]  bcd_t;          // one bcd digit
    typedef logic [11:0] display_t;      // three digits, newest in low nibble
    typedef logic [15:0] keys_t;         // one-hot keypad lines
    typedef logic [1:0]  digit_count_t;  // 0 to 3 digits held
    typedef logic [3:0]  fail_count_t;   // failed attempts

    typedef enum logic [1:0] {
        BUZZ_CLICK = 2'd0,               // short key click
        BUZZ_PASS  = 2'd1,               // long high tone
        BUZZ_FAIL  = 2'd2                // interrupted low tone
    } buzz_kind_t;

    // control keys
    localparam keys_t KEY_ENTER  = 16'h0001;
    localparam keys_t KEY_MASTER = 16'h0100;
    localparam keys_t KEY_CLEAR  = 16'h1000;

    // digit keys, as the keypad matrix is wired
    localparam keys_t KEY_D0 = 16'h0008;
    localparam keys_t KEY_D1 = 16'h0080;
    localparam keys_t KEY_D2 = 16'h0040;
    localparam keys_t KEY_D3 = 16'h0020;
    localparam keys_t KEY_D4 = 16'h0800;
    localparam keys_t KEY_D5 = 16'h0400;
    localparam keys_t KEY_D6 = 16'h0200;
    localparam keys_t KEY_D7 = 16'h8000;
    localparam keys_t KEY_D8 = 16'h4000;
    localparam keys_t KEY_D9 = 16'h2000;

    localparam display_t DISP_BLANK = 12'hFFF;  // all segments dark
    localparam display_t DISP_PASS  = 12'hBCC;  // reads "ASS"
    localparam display_t DISP_LOCK  = 12'h000;  // lockout screen base

endpackage

/* verilog/lockout_timer.sv */
module lockout_timer #(
    parameter int TICKS_PER_SEC = 50
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    output lock_pkg::bcd_t sec_tens,
    output lock_pkg::bcd_t sec_units,
    output logic           done
);

    localparam int PW = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [PW-1:0] LAST_TICK = PW'(TICKS_PER_SEC - 1);

    logic [PW-1:0] prescale;   // cycles within the current second
    logic          tick;       // last cycle of a second

    assign tick = (prescale == LAST_TICK);

    // end of the second that showed 59
    assign done = run && tick && (sec_tens == 4'd5) && (sec_units == 4'd9);

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            prescale  <= '0;
            sec_tens  <= 4'd0;
            sec_units <= 4'd0;
        end else if (tick) begin
            prescale <= '0;
            if (sec_units == 4'd9) begin
                sec_units <= 4'd0;
                sec_tens  <= (sec_tens == 4'd5) ? 4'd0 : sec_tens + 4'd1;  // wrap at 59
            end else begin
                sec_units <= sec_units + 4'd1;
            end
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule
